// ==== hdl/noc_pkg.sv ====
`default_nettype none

package noc_pkg;

   // network shape
   localparam int NUM_VCS = 2;
   localparam int VC_IDX_WIDTH = 1;
   localparam int NUM_PORTS = 2;
   localparam int PORT_IDX_WIDTH = 1;
   localparam int ADDR_WIDTH = 3;

   // flit payload, a head gives up its top bits to the destination
   localparam int FLIT_DATA_WIDTH = 16;
   localparam int HEAD_PAYLOAD_WIDTH = FLIT_DATA_WIDTH - ADDR_WIDTH;

   // channel word is {valid, head, tail, vc, data}
   localparam int CHANNEL_WIDTH = 3 + VC_IDX_WIDTH + FLIT_DATA_WIDTH;
   localparam int CH_VALID_BIT = CHANNEL_WIDTH - 1;
   localparam int CH_HEAD_BIT = CHANNEL_WIDTH - 2;
   localparam int CH_TAIL_BIT = CHANNEL_WIDTH - 3;
   localparam int CH_VC_LSB = FLIT_DATA_WIDTH;

   // credit word is {valid, vc}
   localparam int FLOW_CTRL_WIDTH = 1 + VC_IDX_WIDTH;
   localparam int FC_VALID_BIT = FLOW_CTRL_WIDTH - 1;

   // per-vc buffering and credit counting
   localparam int BUF_DEPTH = 4;
   localparam int PTR_WIDTH = 2;
   localparam int CREDIT_WIDTH = 3;
   // buffer entry is {drop, output port, channel word}
   localparam int BUF_ENTRY_WIDTH = CHANNEL_WIDTH + 2;

   // output numbering inside a router
   localparam logic PORT_LOCAL = 1'b0;
   localparam logic PORT_EAST = 1'b1;

   // allocator candidates are (input, vc) pairs
   localparam int NUM_CAND = NUM_PORTS * NUM_VCS;
   localparam int CAND_WIDTH = PORT_IDX_WIDTH + VC_IDX_WIDTH;

   typedef struct packed {
      logic [ADDR_WIDTH-1:0]         dest;
      logic [HEAD_PAYLOAD_WIDTH-1:0] payload;
   } flit_head_t;

   // head flits carry a destination, body and tail flits are raw payload
   typedef union packed {
      flit_head_t                 head;
      logic [FLIT_DATA_WIDTH-1:0] body;
   } flit_data_t;

endpackage

`default_nettype wire

// ==== hdl/output_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_port (
   input  logic                                clk,
   input  logic                                rst,
   input  logic [noc_pkg::CHANNEL_WIDTH-1:0]   flit_in,
   input  logic                                flit_send,
   input  logic [noc_pkg::FLOW_CTRL_WIDTH-1:0] flow_ctrl_in,
   output logic [noc_pkg::NUM_VCS-1:0]         credit_avail,
   output logic [noc_pkg::CHANNEL_WIDTH-1:0]   channel_out,
   output logic                                error
);
   import noc_pkg::*;

   logic [NUM_VCS-1:0][CREDIT_WIDTH-1:0] credits;
   logic [VC_IDX_WIDTH-1:0] send_vc;
   logic [VC_IDX_WIDTH-1:0] ret_vc;
   logic                    ret_valid;
   logic [NUM_VCS-1:0]      send_v;
   logic [NUM_VCS-1:0]      ret_v;
   logic [NUM_VCS-1:0]      overflow;
   logic                    out_valid;
   logic [CHANNEL_WIDTH-2:0] out_word;

   assign send_vc = flit_in[CH_VC_LSB +: VC_IDX_WIDTH];
   assign ret_valid = flow_ctrl_in[FC_VALID_BIT];
   assign ret_vc = flow_ctrl_in[VC_IDX_WIDTH-1:0];

   always_comb begin
      for (int v = 0; v < NUM_VCS; v++) begin
         send_v[v] = flit_send && (send_vc == VC_IDX_WIDTH'(v));
         // a return into a full counter is lost, unless a send frees a slot
         overflow[v] = ret_valid && (ret_vc == VC_IDX_WIDTH'(v)) &&
                       (credits[v] == CREDIT_WIDTH'(BUF_DEPTH)) && !send_v[v];
         ret_v[v] = ret_valid && (ret_vc == VC_IDX_WIDTH'(v)) && !overflow[v];
         credit_avail[v] = credits[v] != '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int v = 0; v < NUM_VCS; v++) credits[v] <= CREDIT_WIDTH'(BUF_DEPTH);
         out_valid <= 1'b0;
         error <= 1'b0;
      end else begin
         for (int v = 0; v < NUM_VCS; v++) credits[v] <= credits[v] - send_v[v] + ret_v[v];
         out_valid <= flit_send;
         error <= error || (|overflow);
      end
   end

   // flit fields below the valid bit
   always_ff @(posedge clk) begin
      if (flit_send) out_word <= flit_in[CHANNEL_WIDTH-2:0];
   end

   assign channel_out = {out_valid, out_word};

   for (genvar v = 0; v < NUM_VCS; v++) begin : g_cred_chk
      assert property (@(posedge clk) disable iff (rst) credits[v] <= CREDIT_WIDTH'(BUF_DEPTH));
   end
   // the allocator only sends on a vc the downstream buffer has room for
   assert property (@(posedge clk) disable iff (rst) flit_send |-> credit_avail[send_vc]);

endmodule

`default_nettype wire

// ==== hdl/router.sv ====
`timescale 1ns/1ps
`default_nettype none

module router (
   input  logic                                clk,
   input  logic                                rst,
   input  logic [noc_pkg::ADDR_WIDTH-1:0]      router_address,
   input  logic [noc_pkg::CHANNEL_WIDTH-1:0]   channel_in_local,
   input  logic [noc_pkg::CHANNEL_WIDTH-1:0]   channel_in_west,
   output logic [noc_pkg::FLOW_CTRL_WIDTH-1:0] flow_ctrl_out_local,
   output logic [noc_pkg::FLOW_CTRL_WIDTH-1:0] flow_ctrl_out_west,
   output logic [noc_pkg::CHANNEL_WIDTH-1:0]   channel_out_local,
   output logic [noc_pkg::CHANNEL_WIDTH-1:0]   channel_out_east,
   input  logic [noc_pkg::FLOW_CTRL_WIDTH-1:0] flow_ctrl_in_local,
   input  logic [noc_pkg::FLOW_CTRL_WIDTH-1:0] flow_ctrl_in_east,
   output logic                                error
);
   import noc_pkg::*;

   // per input: [0] local, [1] west
   logic [NUM_PORTS-1:0][NUM_VCS-1:0] req;
   logic [NUM_PORTS-1:0][NUM_VCS-1:0] req_port;
   logic [NUM_PORTS-1:0][NUM_VCS-1:0] head_tail;
   logic [NUM_PORTS-1:0][NUM_VCS-1:0] grant;
   logic [NUM_PORTS-1:0][NUM_VCS-1:0][CHANNEL_WIDTH-1:0] head_flit;
   logic [NUM_PORTS-1:0][CHANNEL_WIDTH-1:0] in_channel;
   logic [NUM_PORTS-1:0][FLOW_CTRL_WIDTH-1:0] in_credit;
   logic [NUM_PORTS-1:0] in_error;

   // per output: [0] local, [1] east
   logic [NUM_PORTS-1:0][NUM_VCS-1:0] credit_avail;
   logic [NUM_PORTS-1:0][PORT_IDX_WIDTH-1:0] sel;
   logic [NUM_PORTS-1:0][CHANNEL_WIDTH-1:0] out_flit;
   logic [NUM_PORTS-1:0][CHANNEL_WIDTH-1:0] out_channel;
   logic [NUM_PORTS-1:0][FLOW_CTRL_WIDTH-1:0] out_credit;
   logic [NUM_PORTS-1:0] out_send;
   logic [NUM_PORTS-1:0] out_error;

   // granted flit and its port, per input
   logic [NUM_PORTS-1:0][CHANNEL_WIDTH-1:0] gnt_flit;
   logic [NUM_PORTS-1:0] gnt_port;

   assign in_channel = {channel_in_west, channel_in_local};
   assign flow_ctrl_out_local = in_credit[0];
   assign flow_ctrl_out_west = in_credit[1];
   assign out_credit = {flow_ctrl_in_east, flow_ctrl_in_local};
   assign channel_out_local = out_channel[0];
   assign channel_out_east = out_channel[1];

   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
      vc_input_buffer u_ibuf (
         .clk(clk), .rst(rst), .router_address(router_address),
         .channel_in(in_channel[i]), .flow_ctrl_out(in_credit[i]),
         .req(req[i]), .req_port(req_port[i]), .head_flit(head_flit[i]),
         .grant(grant[i]), .error(in_error[i]));
      for (genvar v = 0; v < NUM_VCS; v++) begin : g_tail
         assign head_tail[i][v] = head_flit[i][v][CH_TAIL_BIT];
      end
   end

   switch_allocator u_alloc (
      .clk(clk), .rst(rst),
      .req0(req[0]), .req1(req[1]),
      .req_port0(req_port[0]), .req_port1(req_port[1]),
      .head_tail0(head_tail[0]), .head_tail1(head_tail[1]),
      .credit_avail0(credit_avail[0]), .credit_avail1(credit_avail[1]),
      .grant0(grant[0]), .grant1(grant[1]),
      .sel0(sel[0]), .sel1(sel[1]));

   // crossbar, each input has at most one granted vc
   always_comb begin
      gnt_flit = '0;
      gnt_port = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
         for (int v = 0; v < NUM_VCS; v++) begin
            if (grant[i][v]) begin
               gnt_flit[i] = head_flit[i][v];
               gnt_port[i] = req_port[i][v];
            end
         end
      end
      for (int o = 0; o < NUM_PORTS; o++) begin
         out_flit[o] = gnt_flit[sel[o]];
         out_send[o] = 1'b0;
         for (int i = 0; i < NUM_PORTS; i++) begin
            if ((grant[i] != '0) && (gnt_port[i] == o)) out_send[o] = 1'b1;
         end
      end
   end

   for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
      output_port u_oport (
         .clk(clk), .rst(rst), .flit_in(out_flit[o]), .flit_send(out_send[o]),
         .flow_ctrl_in(out_credit[o]), .credit_avail(credit_avail[o]),
         .channel_out(out_channel[o]), .error(out_error[o]));
   end

   assign error = (|in_error) || (|out_error);

endmodule

`default_nettype wire

// ==== hdl/router_pair.sv ====
`timescale 1ns/1ps
`default_nettype none

module router_pair (
   input  logic                                clk,
   input  logic                                rst,
   input  logic [noc_pkg::ADDR_WIDTH-1:0]      router_address,
   // router a local and west side
   input  logic [noc_pkg::CHANNEL_WIDTH-1:0]   channel_in_local_a,
   output logic [noc_pkg::FLOW_CTRL_WIDTH-1:0] flow_ctrl_out_local_a,
   input  logic [noc_pkg::CHANNEL_WIDTH-1:0]   channel_in_west,
   output logic [noc_pkg::FLOW_CTRL_WIDTH-1:0] flow_ctrl_out_west,
   output logic [noc_pkg::CHANNEL_WIDTH-1:0]   channel_out_local_a,
   input  logic [noc_pkg::FLOW_CTRL_WIDTH-1:0] flow_ctrl_in_local_a,
   // router b local and east side
   input  logic [noc_pkg::CHANNEL_WIDTH-1:0]   channel_in_local_b,
   output logic [noc_pkg::FLOW_CTRL_WIDTH-1:0] flow_ctrl_out_local_b,
   output logic [noc_pkg::CHANNEL_WIDTH-1:0]   channel_out_local_b,
   input  logic [noc_pkg::FLOW_CTRL_WIDTH-1:0] flow_ctrl_in_local_b,
   output logic [noc_pkg::CHANNEL_WIDTH-1:0]   channel_out_east,
   input  logic [noc_pkg::FLOW_CTRL_WIDTH-1:0] flow_ctrl_in_east,
   output logic                                rtr_error
);
   import noc_pkg::*;

   // link from a east into b west, credits flow back
   logic [CHANNEL_WIDTH-1:0]   link_flit;
   logic [FLOW_CTRL_WIDTH-1:0] link_credit;
   logic [ADDR_WIDTH-1:0]      address_b;
   logic                       error_a;
   logic                       error_b;

   // b sits one hop east of a
   assign address_b = router_address + 1'b1;

   router rtr_a (
      .clk(clk), .rst(rst), .router_address(router_address),
      .channel_in_local(channel_in_local_a), .channel_in_west(channel_in_west),
      .flow_ctrl_out_local(flow_ctrl_out_local_a), .flow_ctrl_out_west(flow_ctrl_out_west),
      .channel_out_local(channel_out_local_a), .channel_out_east(link_flit),
      .flow_ctrl_in_local(flow_ctrl_in_local_a), .flow_ctrl_in_east(link_credit),
      .error(error_a));

   router rtr_b (
      .clk(clk), .rst(rst), .router_address(address_b),
      .channel_in_local(channel_in_local_b), .channel_in_west(link_flit),
      .flow_ctrl_out_local(flow_ctrl_out_local_b), .flow_ctrl_out_west(link_credit),
      .channel_out_local(channel_out_local_b), .channel_out_east(channel_out_east),
      .flow_ctrl_in_local(flow_ctrl_in_local_b), .flow_ctrl_in_east(flow_ctrl_in_east),
      .error(error_b));

   assign rtr_error = error_a | error_b;

endmodule

`default_nettype wire

// ==== hdl/switch_allocator.sv ====
`timescale 1ns/1ps
`default_nettype none

module switch_allocator (
   input  logic                                clk,
   input  logic                                rst,
   input  logic [noc_pkg::NUM_VCS-1:0]         req0,
   input  logic [noc_pkg::NUM_VCS-1:0]         req1,
   input  logic [noc_pkg::NUM_VCS-1:0]         req_port0,
   input  logic [noc_pkg::NUM_VCS-1:0]         req_port1,
   input  logic [noc_pkg::NUM_VCS-1:0]         head_tail0,
   input  logic [noc_pkg::NUM_VCS-1:0]         head_tail1,
   input  logic [noc_pkg::NUM_VCS-1:0]         credit_avail0,
   input  logic [noc_pkg::NUM_VCS-1:0]         credit_avail1,
   output logic [noc_pkg::NUM_VCS-1:0]         grant0,
   output logic [noc_pkg::NUM_VCS-1:0]         grant1,
   output logic [noc_pkg::PORT_IDX_WIDTH-1:0] sel0,
   output logic [noc_pkg::PORT_IDX_WIDTH-1:0] sel1
);
   import noc_pkg::*;

   // requests indexed [input][vc], credits indexed [output][vc]
   logic [NUM_PORTS-1:0][NUM_VCS-1:0] req_a;
   logic [NUM_PORTS-1:0][NUM_VCS-1:0] port_a;
   logic [NUM_PORTS-1:0][NUM_VCS-1:0] tail_a;
   logic [NUM_PORTS-1:0][NUM_VCS-1:0] cred_a;
   logic [NUM_PORTS-1:0][NUM_VCS-1:0] grant_a;

   // wormhole lock per output and vc, holding the owning input
   logic [NUM_PORTS-1:0][NUM_VCS-1:0]                     lock_valid;
   logic [NUM_PORTS-1:0][NUM_VCS-1:0][PORT_IDX_WIDTH-1:0] lock_in;

   logic [NUM_PORTS-1:0][CAND_WIDTH-1:0]     ptr;
   logic [NUM_PORTS-1:0][CAND_WIDTH-1:0]     pick;
   logic [NUM_PORTS-1:0]                     pick_valid;
   logic [NUM_PORTS-1:0][PORT_IDX_WIDTH-1:0] pick_in;
   logic [NUM_PORTS-1:0][VC_IDX_WIDTH-1:0]   pick_vc;

   assign req_a = {req1, req0};
   assign port_a = {req_port1, req_port0};
   assign tail_a = {head_tail1, head_tail0};
   assign cred_a = {credit_avail1, credit_avail0};

   // outputs arbitrate in turn, an input already served is skipped
   always_comb begin : arbitrate
      logic [NUM_PORTS-1:0] taken;
      int k;
      int ki;
      int kv;
      taken = '0;
      pick = '0;
      pick_valid = '0;
      grant_a = '0;
      for (int o = 0; o < NUM_PORTS; o++) begin
         for (int n = 0; n < NUM_CAND; n++) begin
            k = (int'(ptr[o]) + n) % NUM_CAND;
            ki = k / NUM_VCS;
            kv = k % NUM_VCS;
            if (!pick_valid[o] && !taken[ki] && req_a[ki][kv] && (port_a[ki][kv] == o) &&
                cred_a[o][kv] && (!lock_valid[o][kv] || (lock_in[o][kv] == ki))) begin
               pick_valid[o] = 1'b1;
               pick[o] = CAND_WIDTH'(k);
               grant_a[ki][kv] = 1'b1;
            end
         end
         pick_in[o] = pick[o][CAND_WIDTH-1 -: PORT_IDX_WIDTH];
         pick_vc[o] = pick[o][VC_IDX_WIDTH-1:0];
         if (pick_valid[o]) taken[pick_in[o]] = 1'b1;
      end
   end

   assign grant0 = grant_a[0];
   assign grant1 = grant_a[1];
   assign sel0 = pick_in[0];
   assign sel1 = pick_in[1];

   always_ff @(posedge clk) begin
      if (rst) begin
         ptr <= '0;
         lock_valid <= '0;
         lock_in <= '0;
      end else begin
         for (int o = 0; o < NUM_PORTS; o++) begin
            if (pick_valid[o]) begin
               ptr[o] <= pick[o] + 1'b1;
               lock_valid[o][pick_vc[o]] <= !tail_a[pick_in[o]][pick_vc[o]];
               lock_in[o][pick_vc[o]] <= pick_in[o];
            end
         end
      end
   end

   // one credit word per input and cycle means one pop per input
   assert property (@(posedge clk) disable iff (rst) $onehot0(grant0) && $onehot0(grant1));
   for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out_chk
      assert property (@(posedge clk) disable iff (rst)
         $onehot0({grant1 & ~(req_port1 ^ {NUM_VCS{PORT_IDX_WIDTH'(o)}}),
                   grant0 & ~(req_port0 ^ {NUM_VCS{PORT_IDX_WIDTH'(o)}})}));
   end
   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_cred_chk
      for (genvar v = 0; v < NUM_VCS; v++) begin : g_vc
         assert property (@(posedge clk) disable iff (rst)
            grant_a[i][v] |-> cred_a[port_a[i][v]][v]);
      end
   end

endmodule

`default_nettype wire

// ==== hdl/vc_input_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module vc_input_buffer (
   input  logic                                                   clk,
   input  logic                                                   rst,
   input  logic [noc_pkg::ADDR_WIDTH-1:0]                         router_address,
   input  logic [noc_pkg::CHANNEL_WIDTH-1:0]                      channel_in,
   output logic [noc_pkg::FLOW_CTRL_WIDTH-1:0]                    flow_ctrl_out,
   output logic [noc_pkg::NUM_VCS-1:0]                            req,
   output logic [noc_pkg::NUM_VCS-1:0]                            req_port,
   output logic [noc_pkg::NUM_VCS-1:0][noc_pkg::CHANNEL_WIDTH-1:0] head_flit,
   input  logic [noc_pkg::NUM_VCS-1:0]                            grant,
   output logic                                                   error
);
   import noc_pkg::*;

   logic                    in_valid;
   logic                    in_head;
   logic                    in_tail;
   logic [VC_IDX_WIDTH-1:0] in_vc;
   flit_data_t              in_data;
   logic                    dest_west;
   logic                    dest_east;
   logic                    in_drop;
   logic                    in_port;
   logic                    arrive_full;
   logic                    orphan;

   // packet state seen at the input side, per vc
   logic [NUM_VCS-1:0] pkt_open;
   logic [NUM_VCS-1:0] pkt_drop;
   logic [NUM_VCS-1:0] pkt_port;

   logic [BUF_ENTRY_WIDTH-1:0]            mem [NUM_VCS][BUF_DEPTH];
   logic [NUM_VCS-1:0][BUF_ENTRY_WIDTH-1:0] head_entry;
   logic [NUM_VCS-1:0][PTR_WIDTH-1:0]     wr_ptr;
   logic [NUM_VCS-1:0][PTR_WIDTH-1:0]     rd_ptr;
   logic [NUM_VCS-1:0][CREDIT_WIDTH-1:0]  count;
   logic [NUM_VCS-1:0] full;
   logic [NUM_VCS-1:0] push;
   logic [NUM_VCS-1:0] pop;
   logic [NUM_VCS-1:0] discard;
   logic [VC_IDX_WIDTH-1:0] pop_vc;

   assign in_valid = channel_in[CH_VALID_BIT];
   assign in_head = channel_in[CH_HEAD_BIT];
   assign in_tail = channel_in[CH_TAIL_BIT];
   assign in_vc = channel_in[CH_VC_LSB +: VC_IDX_WIDTH];
   // same data word, read back through the head view
   assign in_data.body = channel_in[FLIT_DATA_WIDTH-1:0];
   assign dest_west = in_data.head.dest < router_address;
   assign dest_east = in_data.head.dest > router_address;

   // heads pick the route, body and tail follow the open packet of their vc
   assign in_drop = in_head ? dest_west : (!pkt_open[in_vc] || pkt_drop[in_vc]);
   assign in_port = in_head ? (dest_east ? PORT_EAST : PORT_LOCAL) : pkt_port[in_vc];
   assign orphan = in_valid && !in_head && !pkt_open[in_vc];
   assign arrive_full = in_valid && full[in_vc];

   always_comb begin
      pop_vc = '0;
      for (int v = 0; v < NUM_VCS; v++) begin
         full[v] = count[v] == CREDIT_WIDTH'(BUF_DEPTH);
         push[v] = in_valid && (in_vc == VC_IDX_WIDTH'(v)) && !full[v];
         head_entry[v] = mem[v][rd_ptr[v]];
         head_flit[v] = head_entry[v][CHANNEL_WIDTH-1:0];
         req_port[v] = head_entry[v][BUF_ENTRY_WIDTH-2];
         req[v] = (count[v] != '0) && !head_entry[v][BUF_ENTRY_WIDTH-1];
         // dropped flits drain only in cycles with no grant, one per cycle
         discard[v] = (count[v] != '0) && head_entry[v][BUF_ENTRY_WIDTH-1] &&
                      (grant == '0) && ((discard & ((1 << v) - 1)) == '0);
         pop[v] = grant[v] || discard[v];
         if (pop[v]) pop_vc = VC_IDX_WIDTH'(v);
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && !full[in_vc]) mem[in_vc][wr_ptr[in_vc]] <= {in_drop, in_port, channel_in};
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
         pkt_open <= '0;
         pkt_drop <= '0;
         pkt_port <= '0;
         flow_ctrl_out <= '0;
         error <= 1'b0;
      end else begin
         for (int v = 0; v < NUM_VCS; v++) begin
            if (push[v]) wr_ptr[v] <= wr_ptr[v] + 1'b1;
            if (pop[v]) rd_ptr[v] <= rd_ptr[v] + 1'b1;
            count[v] <= count[v] + push[v] - pop[v];
         end
         if (in_valid && in_head) begin
            pkt_open[in_vc] <= !in_tail;
            pkt_drop[in_vc] <= dest_west;
            pkt_port[in_vc] <= dest_east;
         end else if (in_valid && in_tail) begin
            pkt_open[in_vc] <= 1'b0;
         end
         // every pop frees a slot upstream, dropped flits included
         flow_ctrl_out <= {|pop, pop_vc};
         error <= error || arrive_full || orphan || (in_valid && in_head && dest_west);
      end
   end

   // upstream credit accounting never overruns a healthy buffer
   assert property (@(posedge clk) disable iff (rst) !error |-> !arrive_full);
   // a grant only lands on a requesting vc and never pops an empty fifo
   assert property (@(posedge clk) disable iff (rst) (grant & ~req) == '0);

endmodule

`default_nettype wire

// ==== router_pair.f ====
hdl/noc_pkg.sv
hdl/vc_input_buffer.sv
hdl/switch_allocator.sv
hdl/output_port.sv
hdl/router.sv
hdl/router_pair.sv
verification/router_pair_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the router pair with its testbench and run it under verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module router_pair_tb \
   -f router_pair.f --Mdir obj_dir -o router_pair_sim > build.log 2>&1 \
   && ./obj_dir/router_pair_sim > sim.log 2>&1 \
   || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -qx "Test OK" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }

// ==== verification/router_pair_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module router_pair_tb;
   import noc_pkg::*;

   localparam logic [ADDR_WIDTH-1:0] ADDR_A = 3'd2;
   // routing, two contention runs of 3 x 13 flits, error phase
   localparam int TOTAL_FLITS = 18 + 2 * 3 * 13 + 9;
   localparam int CYCLE_LIMIT = 40 * TOTAL_FLITS + 200;

   logic clk = 1'b0;
   logic rst = 1'b1;
   logic rtr_error;
   // sources 0 local a, 1 west, 2 local b
   logic [CHANNEL_WIDTH-1:0]   src_chan [3];
   logic [FLOW_CTRL_WIDTH-1:0] src_fc [3];
   // sinks 0 local a, 1 local b, 2 east
   logic [CHANNEL_WIDTH-1:0]   sink_chan [3];
   logic [FLOW_CTRL_WIDTH-1:0] sink_fc [3];

   // scoreboard, one queue per (source, vc, sink)
   logic [CHANNEL_WIDTH-2:0] exp_q [24][$];
   int src_sent [3][NUM_VCS];
   int src_ret [3][NUM_VCS];
   // sink side view of the credits the dut holds
   int sink_cred [3][NUM_VCS];
   logic sink_open [3][NUM_VCS];
   int sink_src [3][NUM_VCS];
   int sink_wait [3];
   logic [31:0] lcg_state = 32'h8b45;
   int delay_mask = 3;
   int cycle_count = 0;
   int value_errors = 0;
   int other_errors = 0;
   logic injected = 1'b0;
   logic error_expected = 1'b0;
   logic error_seen = 1'b0;
   string test_name = "reset";

   router_pair DUT (
      .clk(clk), .rst(rst), .router_address(ADDR_A),
      .channel_in_local_a(src_chan[0]), .flow_ctrl_out_local_a(src_fc[0]),
      .channel_in_west(src_chan[1]), .flow_ctrl_out_west(src_fc[1]),
      .channel_out_local_a(sink_chan[0]), .flow_ctrl_in_local_a(sink_fc[0]),
      .channel_in_local_b(src_chan[2]), .flow_ctrl_out_local_b(src_fc[2]),
      .channel_out_local_b(sink_chan[1]), .flow_ctrl_in_local_b(sink_fc[1]),
      .channel_out_east(sink_chan[2]), .flow_ctrl_in_east(sink_fc[2]),
      .rtr_error(rtr_error));

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // own address ejects locally, anything above travels east
   function automatic int sink_of(input int dest);
      if (dest == int'(ADDR_A)) return 0;
      if (dest == int'(ADDR_A) + 1) return 1;
      return 2;
   endfunction

   function automatic bit is_idle();
      bit idle;
      idle = 1'b1;
      for (int q = 0; q < 24; q++) begin
         if (exp_q[q].size() != 0) idle = 1'b0;
      end
      for (int s = 0; s < 3; s++) begin
         for (int v = 0; v < NUM_VCS; v++) begin
            if (src_sent[s][v] != src_ret[s][v] || sink_cred[s][v] != BUF_DEPTH) idle = 1'b0;
         end
      end
      return idle;
   endfunction

   // one packet, a flit leaves only while the source holds a credit
   task automatic send_packet(input int src, input int vc, input int dest, input int len,
                              input int seq);
      flit_data_t data;
      logic [31:0] mix;
      logic [CHANNEL_WIDTH-1:0] word;
      int q;
      bit legal;
      q = (src * NUM_VCS + vc) * 3 + sink_of(dest);
      // local b injects one hop further east
      legal = dest >= int'(ADDR_A) + ((src == 2) ? 1 : 0);
      for (int i = 0; i < len; i++) begin
         mix = lcg_next(32'h8b45 ^ {src[7:0], seq[15:0], i[7:0]});
         data.body = mix[31:16];
         if (i == 0) begin
            data.head.dest = ADDR_WIDTH'(dest);
            // source tag lets the sink find the right queue
            data.head.payload = {src[1:0], seq[10:0]};
         end
         word = {1'b1, i == 0, i == len - 1, VC_IDX_WIDTH'(vc), data};
         while (src_sent[src][vc] - src_ret[src][vc] >= BUF_DEPTH) begin
            @(posedge clk);
            #1;
         end
         src_chan[src] = word;
         src_sent[src][vc]++;
         if (legal) exp_q[q].push_back(word[CHANNEL_WIDTH-2:0]);
         @(posedge clk);
         #1;
         src_chan[src] = '0;
      end
   endtask

   // both vcs, sinks local b and east, lengths 1 to 4
   task automatic run_source(input int src, input int seq_base);
      for (int k = 0; k < 6; k++) begin
         send_packet(src, k % 2, int'(ADDR_A) + (((k / 2) % 2 == 1) ? 4 : 1), 1 + k % 4,
                     seq_base + k);
      end
   endtask

   task automatic wait_idle();
      while (!is_idle()) begin
         @(posedge clk);
         #1;
      end
   endtask

   always #4 clk = ~clk;

   always @(posedge clk) cycle_count <= cycle_count + 1;

   initial begin
      wait (cycle_count >= CYCLE_LIMIT);
      $display("timeout after %0d cycles, traffic did not drain", cycle_count);
      $display("Test FAILED");
      $finish;
   end

   // credits back to the sources, idle state after reset, sticky error flag
   always @(posedge clk) begin
      #1;
      if (!rst) begin
         for (int s = 0; s < 3; s++) begin
            if (src_fc[s][FC_VALID_BIT]) src_ret[s][src_fc[s][VC_IDX_WIDTH-1:0]]++;
            assert (injected || !(src_fc[s][FC_VALID_BIT] || sink_chan[s][CH_VALID_BIT]))
            else begin
               other_errors++;
               $display("port %0d shows a valid bit before any injection", s);
            end
         end
         assert (error_expected || !rtr_error) else begin
            other_errors++;
            $display("rtr_error raised without an illegal packet");
         end
         assert (!error_seen || rtr_error) else begin
            other_errors++;
            $display("rtr_error dropped after it was raised");
         end
         error_seen = error_seen || rtr_error;
      end
   end

   // sinks check every flit and hand credits back after a random delay
   always @(posedge clk) begin : sink_model
      logic [CHANNEL_WIDTH-1:0] f;
      logic [CHANNEL_WIDTH-2:0] expected;
      flit_data_t data;
      int vc;
      int q;
      int rv;
      #1;
      for (int s = 0; s < 3; s++) begin
         f = sink_chan[s];
         sink_fc[s] = '0;
         if (!rst && f[CH_VALID_BIT]) begin
            vc = int'(f[CH_VC_LSB +: VC_IDX_WIDTH]);
            data.body = f[FLIT_DATA_WIDTH-1:0];
            assert (sink_cred[s][vc] > 0) else begin
               other_errors++;
               $display("sink %0d got a flit on vc %0d with no credit left", s, vc);
            end
            sink_cred[s][vc]--;
            if (f[CH_HEAD_BIT]) begin
               // wormhole, a new head only after the previous tail
               assert (!sink_open[s][vc]) else begin
                  other_errors++;
                  $display("%s: head on sink %0d vc %0d inside an open packet", test_name, s, vc);
               end
               sink_src[s][vc] = int'(data.head.payload[HEAD_PAYLOAD_WIDTH-1 -: 2]);
               sink_open[s][vc] = 1'b1;
            end else begin
               assert (sink_open[s][vc]) else begin
                  other_errors++;
                  $display("%s: body flit on sink %0d vc %0d with no open packet", test_name, s, vc);
               end
            end
            if (f[CH_TAIL_BIT]) sink_open[s][vc] = 1'b0;
            q = (sink_src[s][vc] * NUM_VCS + vc) * 3 + s;
            assert (exp_q[q].size() != 0) else begin
               other_errors++;
               $display("%s: unexpected flit %h at sink %0d", test_name, f, s);
            end
            if (exp_q[q].size() != 0) begin
               expected = exp_q[q].pop_front();
               assert (f[CHANNEL_WIDTH-2:0] == expected) else begin
                  value_errors++;
                  $display("[ERROR] %s: expected %h, actual %h", test_name, expected,
                           f[CHANNEL_WIDTH-2:0]);
               end
            end
         end
         // at most one credit word per sink and cycle
         if (sink_wait[s] > 0) begin
            sink_wait[s]--;
         end else if (sink_cred[s][0] < BUF_DEPTH || sink_cred[s][1] < BUF_DEPTH) begin
            lcg_state = lcg_next(lcg_state);
            rv = (sink_cred[s][1] < BUF_DEPTH &&
                  (lcg_state[20] || sink_cred[s][0] == BUF_DEPTH)) ? 1 : 0;
            sink_fc[s] = {1'b1, VC_IDX_WIDTH'(rv)};
            sink_cred[s][rv]++;
            sink_wait[s] = int'(lcg_state[27:24]) & delay_mask;
         end
      end
   end

   initial begin
      for (int s = 0; s < 3; s++) begin
         src_chan[s] = '0;
         sink_fc[s] = '0;
         sink_wait[s] = 0;
         for (int v = 0; v < NUM_VCS; v++) begin
            src_sent[s][v] = 0;
            src_ret[s][v] = 0;
            sink_cred[s][v] = BUF_DEPTH;
            sink_open[s][v] = 1'b0;
            sink_src[s][v] = 0;
         end
      end
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      // quiet cycles to watch the post reset state
      repeat (6) @(posedge clk);
      #1;
      injected = 1'b1;
      test_name = "routing";
      send_packet(0, 0, 2, 1, 1);
      send_packet(0, 1, 3, 3, 2);
      send_packet(0, 0, 5, 2, 3);
      send_packet(1, 1, 2, 2, 4);
      send_packet(1, 0, 3, 1, 5);
      send_packet(1, 1, 7, 4, 6);
      send_packet(2, 0, 3, 2, 7);
      send_packet(2, 1, 4, 3, 8);
      wait_idle();
      test_name = "contention";
      fork
         run_source(0, 16);
         run_source(1, 32);
         run_source(2, 48);
      join
      wait_idle();
      // long credit holds at the sinks
      test_name = "backpressure";
      delay_mask = 15;
      fork
         run_source(0, 64);
         run_source(1, 80);
         run_source(2, 96);
      join
      wait_idle();
      delay_mask = 3;
      // heads below router a, dropped whole at local a and west
      test_name = "error";
      error_expected = 1'b1;
      send_packet(0, 0, 1, 3, 200);
      send_packet(1, 1, 0, 1, 201);
      while (!rtr_error) begin
         @(posedge clk);
         #1;
      end
      send_packet(0, 0, 3, 2, 202);
      send_packet(1, 1, 2, 2, 203);
      send_packet(2, 0, 5, 1, 204);
      wait_idle();
      $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
